/* mem_port_params.svh */
////////////////////
// memory port parameters
// bus widths and the owner turnaround
// length for the shared memory front end
////////////////////

`ifndef MEM_PORT_PARAMS_SVH
`define MEM_PORT_PARAMS_SVH

// byte address into memory
`define MEM_ADDR_W 32

// one double word per bus beat
`define MEM_DATA_W 64

// response and tag width
// zero on either means nothing came back
`define MEM_TAG_W 4

// dead cycles after the desired owner changes
`define MEM_TURNAROUND 1

`endif

/* mem_port_pkg.sv */
////////////////////
// memory port types
// bus commands, access sizes, bus owner
// and the error status of the front end
////////////////////

package mem_port_pkg;

    // command on the tagged memory bus
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // access size, fetch always uses double
    typedef enum logic [1:0] {
        size_byte   = 2'h0,
        size_half   = 2'h1,
        size_word   = 2'h2,
        size_double = 2'h3
    } mem_size_t;

    // side that holds the shared bus
    typedef enum logic [1:0] {
        owner_none = 2'h0,
        owner_data = 2'h1,
        owner_inst = 2'h2
    } bus_owner_t;

    // status reported out of the core
    typedef enum logic [1:0] {
        no_error      = 2'h0,
        illegal_inst  = 2'h1,
        halted_on_wfi = 2'h2
    } error_status_t;

endpackage

/* request_select.sv */
////////////////////
// request select
// picks the bus request between the data
// cache and instruction fetch, and names
// the side that wants the bus
////////////////////

`timescale 1ns/1ps
`include "mem_port_params.svh"

module request_select (
    // data cache request
    input  mem_port_pkg::bus_command_t  dcache_command,
    input  logic [`MEM_ADDR_W-1:0]      dcache_addr,
    input  logic [`MEM_DATA_W-1:0]      dcache_data,
    input  mem_port_pkg::mem_size_t     dcache_size,
    // fetch address
    input  logic [`MEM_ADDR_W-1:0]      imem_addr,
    // request onto the bus
    output mem_port_pkg::bus_command_t  mem_command,
    output logic [`MEM_ADDR_W-1:0]      mem_addr,
    output logic [`MEM_DATA_W-1:0]      mem_wdata,
    output mem_port_pkg::mem_size_t     mem_size,
    output mem_port_pkg::bus_owner_t    desired_owner
);

    ////////////////////
    // priority mux
    ////////////////////

    always_comb begin
        if (dcache_command != mem_port_pkg::bus_none) begin
            // data side wins, whole request passes through
            mem_command   = dcache_command;
            mem_addr      = dcache_addr;
            mem_wdata     = dcache_data;
            mem_size      = dcache_size;
            desired_owner = mem_port_pkg::owner_data;
        end else begin
            // idle data side, fetch a double word
            mem_command   = mem_port_pkg::bus_load;
            mem_addr      = imem_addr;
            // loads carry no write data
            mem_wdata     = '0;
            mem_size      = mem_port_pkg::size_double;
            desired_owner = mem_port_pkg::owner_inst;
        end
    end

endmodule

/* owner_tracker.sv */
////////////////////
// owner tracker
// holds the bus owner and counts the
// turnaround after each owner change
////////////////////

`timescale 1ns/1ps
`include "mem_port_params.svh"

module owner_tracker (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_port_pkg::bus_owner_t  desired_owner,
    // current owner is done with the bus
    input  logic                      bus_release,
    output mem_port_pkg::bus_owner_t  owner,
    output logic                      turnaround_done
);

    // wide enough to hold the turnaround length
    localparam int cnt_w = $clog2(`MEM_TURNAROUND + 1);

    logic [cnt_w-1:0] wait_count;
    logic             owner_change;
    logic             handover;

    // someone else wants the bus
    assign owner_change = (desired_owner != owner);

    // handover only once the old owner lets go, or nobody holds it
    assign handover = owner_change &&
                      (bus_release || owner == mem_port_pkg::owner_none);

    ////////////////////
    // owner and counter
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner      <= mem_port_pkg::owner_none;
            wait_count <= cnt_w'(1);
        end else begin
            // restart the count on every pending change
            if (owner_change) begin
                wait_count <= cnt_w'(`MEM_TURNAROUND);
            end else if (wait_count != '0) begin
                wait_count <= wait_count - 1'b1;
            end
            if (handover) begin
                owner <= desired_owner;
            end
        end
    end

    // counter parked at zero once expired
    assign turnaround_done = (wait_count == '0);

endmodule

/* response_router.sv */
////////////////////
// response router
// steers the memory response to the side
// that owns the bus, raises release when
// that side is answered or pre-empted
////////////////////

`timescale 1ns/1ps
`include "mem_port_params.svh"

module response_router (
    input  mem_port_pkg::bus_owner_t  owner,
    input  mem_port_pkg::bus_owner_t  desired_owner,
    input  logic                      turnaround_done,
    input  logic [`MEM_TAG_W-1:0]     mem_response,
    // per side responses
    output logic [`MEM_TAG_W-1:0]     dmem_response,
    output logic [`MEM_TAG_W-1:0]     imem_response,
    output logic                      bus_release,
    output logic                      fetch_stall
);

    // nonzero response means memory took the request
    logic response_seen;

    assign response_seen = (mem_response != '0);

    ////////////////////
    // routing
    ////////////////////

    always_comb begin
        dmem_response = '0;
        imem_response = '0;
        bus_release   = 1'b0;
        fetch_stall   = 1'b0;
        case (owner)
            mem_port_pkg::owner_data: begin
                // fetch waits while data holds the bus
                fetch_stall = 1'b1;
                if (turnaround_done) begin
                    dmem_response = mem_response;
                    bus_release   = response_seen;
                end
            end
            mem_port_pkg::owner_inst: begin
                if (desired_owner == mem_port_pkg::owner_data) begin
                    // data request pre-empts fetch at once
                    bus_release = 1'b1;
                end else if (turnaround_done) begin
                    imem_response = mem_response;
                    bus_release   = response_seen;
                end
            end
            default: begin
                // no owner, response dropped
                bus_release = 1'b0;
            end
        endcase
    end

endmodule

/* halt_control.sv */
////////////////////
// halt control
// sticky halt flag, fetch enable and
// the error status encoding
////////////////////

`timescale 1ns/1ps

module halt_control (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         fetch_stall,
    input  logic                         dispatch_ok,
    input  logic                         retire_stall,
    input  logic                         halt,
    input  logic                         halt_confirm,
    input  logic                         illegal,
    output logic                         fetch_enable,
    output mem_port_pkg::error_status_t  error_status
);

    logic halt_seen;

    // set by retire, held until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            halt_seen <= 1'b0;
        end else if (halt) begin
            halt_seen <= 1'b1;
        end
    end

    // fetch only with room downstream and the bus free
    assign fetch_enable = dispatch_ok && !fetch_stall && !retire_stall && !halt_seen;

    ////////////////////
    // status
    ////////////////////

    // illegal wins over halt
    always_comb begin
        if (illegal) begin
            error_status = mem_port_pkg::illegal_inst;
        end else if (halt_seen && halt_confirm) begin
            // halt counts once the data cache has drained
            error_status = mem_port_pkg::halted_on_wfi;
        end else begin
            error_status = mem_port_pkg::no_error;
        end
    end

endmodule

/* mem_port_top.sv */
////////////////////
// memory port top
// shared memory front end, one tagged bus
// between fetch and the data cache, with
// owner tracking and halt control
////////////////////

`timescale 1ns/1ps
`include "mem_port_params.svh"

module mem_port_top (
    input  logic                         clock,
    input  logic                         reset,
    // data cache request
    input  mem_port_pkg::bus_command_t   dcache_command,
    input  logic [`MEM_ADDR_W-1:0]       dcache_addr,
    input  logic [`MEM_DATA_W-1:0]       dcache_data,
    input  mem_port_pkg::mem_size_t      dcache_size,
    // fetch address
    input  logic [`MEM_ADDR_W-1:0]       imem_addr,
    // memory returns
    input  logic [`MEM_TAG_W-1:0]        mem_response,
    input  logic [`MEM_DATA_W-1:0]       mem_data,
    input  logic [`MEM_TAG_W-1:0]        mem_tag,
    // bus request
    output mem_port_pkg::bus_command_t   mem_command,
    output logic [`MEM_ADDR_W-1:0]       mem_addr,
    output logic [`MEM_DATA_W-1:0]       mem_wdata,
    output mem_port_pkg::mem_size_t      mem_size,
    // responses back to each side
    output logic [`MEM_TAG_W-1:0]        dmem_response,
    output logic [`MEM_TAG_W-1:0]        imem_response,
    output logic [`MEM_DATA_W-1:0]       mem_rdata,
    output logic [`MEM_TAG_W-1:0]        mem_rtag,
    // fetch control
    output logic                         fetch_stall,
    output logic                         fetch_enable,
    // control from the core
    input  logic                         dispatch_ok,
    input  logic                         retire_stall,
    input  logic                         halt,
    input  logic                         halt_confirm,
    input  logic                         illegal,
    output mem_port_pkg::error_status_t  error_status
);

    mem_port_pkg::bus_owner_t desired_owner;
    mem_port_pkg::bus_owner_t owner;
    logic                     turnaround_done;
    logic                     bus_release;

    ////////////////////
    // request path
    ////////////////////

    request_select request_select_i (
        .dcache_command (dcache_command),
        .dcache_addr    (dcache_addr),
        .dcache_data    (dcache_data),
        .dcache_size    (dcache_size),
        .imem_addr      (imem_addr),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_size       (mem_size),
        .desired_owner  (desired_owner)
    );

    owner_tracker owner_tracker_i (
        .clock           (clock),
        .reset           (reset),
        .desired_owner   (desired_owner),
        .bus_release     (bus_release),
        .owner           (owner),
        .turnaround_done (turnaround_done)
    );

    ////////////////////
    // response path
    ////////////////////

    response_router response_router_i (
        .owner           (owner),
        .desired_owner   (desired_owner),
        .turnaround_done (turnaround_done),
        .mem_response    (mem_response),
        .dmem_response   (dmem_response),
        .imem_response   (imem_response),
        .bus_release     (bus_release),
        .fetch_stall     (fetch_stall)
    );

    // data and tag go to both sides, response picks the listener
    assign mem_rdata = mem_data;
    assign mem_rtag  = mem_tag;

    halt_control halt_control_i (
        .clock        (clock),
        .reset        (reset),
        .fetch_stall  (fetch_stall),
        .dispatch_ok  (dispatch_ok),
        .retire_stall (retire_stall),
        .halt         (halt),
        .halt_confirm (halt_confirm),
        .illegal      (illegal),
        .fetch_enable (fetch_enable),
        .error_status (error_status)
    );

endmodule

/* mem_port_assert.sv */
////////////////////
// memory port assertions
// ownership and routing rules on the
// response router outputs
////////////////////

`timescale 1ns/1ps
`include "mem_port_params.svh"

module mem_port_assert (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_port_pkg::bus_owner_t  owner,
    input  logic                      turnaround_done,
    input  logic [`MEM_TAG_W-1:0]     dmem_response,
    input  logic [`MEM_TAG_W-1:0]     imem_response,
    input  logic                      fetch_stall
);

    // one side at most hears the response
    one_side_only: assert property (@(posedge clock) disable iff (reset)
        !(dmem_response != '0 && imem_response != '0))
        else $error("both sides got a memory response in the same cycle");

    // data owner always holds fetch off
    stall_with_data: assert property (@(posedge clock) disable iff (reset)
        owner == mem_port_pkg::owner_data |-> fetch_stall)
        else $error("fetch_stall low while data owns the bus");

    // quiet during the turnaround
    quiet_in_turnaround: assert property (@(posedge clock) disable iff (reset)
        !turnaround_done |-> (dmem_response == '0 && imem_response == '0))
        else $error("response delivered before the turnaround expired");

endmodule

// router signals as seen from the top level
bind mem_port_top mem_port_assert mem_port_assert_i (
    .clock           (clock),
    .reset           (reset),
    .owner           (owner),
    .turnaround_done (turnaround_done),
    .dmem_response   (dmem_response),
    .imem_response   (imem_response),
    .fetch_stall     (fetch_stall)
);

/* mem_port_tb.sv */
////////////////////
// memory port testbench
// directed and random traffic on the shared
// memory front end, checked every cycle
// against a reference model
////////////////////

`timescale 1ns/1ps
`include "mem_port_params.svh"

module mem_port_tb;

    // expected outputs plus next model state for one cycle
    typedef struct packed {
        mem_port_pkg::bus_command_t   command;
        logic [`MEM_ADDR_W-1:0]       addr;
        logic [`MEM_DATA_W-1:0]       wdata;
        mem_port_pkg::mem_size_t      size;
        logic [`MEM_TAG_W-1:0]        dresp;
        logic [`MEM_TAG_W-1:0]        iresp;
        logic                         stall;
        logic                         enable;
        mem_port_pkg::error_status_t  status;
        mem_port_pkg::bus_owner_t     next_owner;
        logic [3:0]                   next_count;
        logic                         next_halt;
    } expected_t;

    // wait conditions
    localparam int until_imem      = 0;
    localparam int until_data_bus  = 1;
    localparam int until_dmem      = 2;
    localparam int until_fetch_bus = 3;
    localparam int until_halted    = 4;
    localparam int until_illegal   = 5;

    logic                         clock;
    logic                         reset;
    mem_port_pkg::bus_command_t   dcache_command;
    logic [`MEM_ADDR_W-1:0]       dcache_addr;
    logic [`MEM_DATA_W-1:0]       dcache_data;
    mem_port_pkg::mem_size_t      dcache_size;
    logic [`MEM_ADDR_W-1:0]       imem_addr;
    logic [`MEM_TAG_W-1:0]        mem_response;
    logic [`MEM_DATA_W-1:0]       mem_data;
    logic [`MEM_TAG_W-1:0]        mem_tag;
    mem_port_pkg::bus_command_t   mem_command;
    logic [`MEM_ADDR_W-1:0]       mem_addr;
    logic [`MEM_DATA_W-1:0]       mem_wdata;
    mem_port_pkg::mem_size_t      mem_size;
    logic [`MEM_TAG_W-1:0]        dmem_response;
    logic [`MEM_TAG_W-1:0]        imem_response;
    logic [`MEM_DATA_W-1:0]       mem_rdata;
    logic [`MEM_TAG_W-1:0]        mem_rtag;
    logic                         fetch_stall;
    logic                         fetch_enable;
    logic                         dispatch_ok;
    logic                         retire_stall;
    logic                         halt;
    logic                         halt_confirm;
    logic                         illegal;
    mem_port_pkg::error_status_t  error_status;

    // model state
    mem_port_pkg::bus_owner_t     model_owner;
    logic [3:0]                   model_count;
    logic                         model_halt;

    mem_port_top mem_port_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic expected_t reference_cycle();
        expected_t                 exp;
        mem_port_pkg::bus_owner_t  want_bus;
        logic                      done;
        logic                      give_up;
        exp = '0;
        give_up = 1'b0;
        // data side first, else a double word fetch
        if (dcache_command != mem_port_pkg::bus_none) begin
            want_bus    = mem_port_pkg::owner_data;
            exp.command = dcache_command;
            exp.addr    = dcache_addr;
            exp.wdata   = dcache_data;
            exp.size    = dcache_size;
        end else begin
            want_bus    = mem_port_pkg::owner_inst;
            exp.command = mem_port_pkg::bus_load;
            exp.addr    = imem_addr;
            exp.size    = mem_port_pkg::size_double;
        end
        done = (model_count == 4'd0);
        if (model_owner == mem_port_pkg::owner_data) begin
            exp.stall = 1'b1;
            if (done) begin
                exp.dresp = mem_response;
                give_up   = (mem_response != '0);
            end
        end else if (model_owner == mem_port_pkg::owner_inst) begin
            // pre-empted by data at once
            if (want_bus == mem_port_pkg::owner_data) begin
                give_up = 1'b1;
            end else if (done) begin
                exp.iresp = mem_response;
                give_up   = (mem_response != '0);
            end
        end
        exp.enable = dispatch_ok && !exp.stall && !retire_stall && !model_halt;
        if (illegal) begin
            exp.status = mem_port_pkg::illegal_inst;
        end else if (model_halt && halt_confirm) begin
            exp.status = mem_port_pkg::halted_on_wfi;
        end else begin
            exp.status = mem_port_pkg::no_error;
        end
        // state after the next rising edge
        if (want_bus != model_owner) begin
            exp.next_count = `MEM_TURNAROUND;
        end else begin
            exp.next_count = done ? 4'd0 : model_count - 4'd1;
        end
        if (want_bus != model_owner && (give_up || model_owner == mem_port_pkg::owner_none)) begin
            exp.next_owner = want_bus;
        end else begin
            exp.next_owner = model_owner;
        end
        exp.next_halt = model_halt || halt;
        return exp;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_command(mem_port_pkg::bus_command_t got,
                                 mem_port_pkg::bus_command_t want);
        if (got !== want) begin
            $display("[ERROR] mem_command got 0x%h expected 0x%h", got, want);
            stop_run();
        end
    endtask

    task automatic check_owner_outputs(logic [`MEM_TAG_W-1:0] got_d,
                                       logic [`MEM_TAG_W-1:0] got_i,
                                       logic [`MEM_TAG_W-1:0] want_d,
                                       logic [`MEM_TAG_W-1:0] want_i);
        if (got_d !== want_d) begin
            $display("[ERROR] dmem_response got 0x%h expected 0x%h", got_d, want_d);
            stop_run();
        end
        if (got_i !== want_i) begin
            $display("[ERROR] imem_response got 0x%h expected 0x%h", got_i, want_i);
            stop_run();
        end
    endtask

    task automatic check_status(mem_port_pkg::error_status_t got,
                                mem_port_pkg::error_status_t want);
        if (got !== want) begin
            $display("[ERROR] error_status got 0x%h expected 0x%h", got, want);
            stop_run();
        end
    endtask

    // addresses, data, and the narrow fields widened
    task automatic check_word(string name, logic [63:0] got, logic [63:0] want);
        if (got !== want) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
            stop_run();
        end
    endtask

    // inputs settle after the rising edge, so compare mid cycle
    always @(negedge clock) begin : compare
        expected_t exp;
        if (reset) begin
            model_owner = mem_port_pkg::owner_none;
            model_count = 4'd1;
            model_halt  = 1'b0;
        end else begin
            exp = reference_cycle();
            check_command(mem_command, exp.command);
            check_word("mem_addr", mem_addr, exp.addr);
            check_word("mem_wdata", mem_wdata, exp.wdata);
            check_word("mem_size", mem_size, exp.size);
            check_owner_outputs(dmem_response, imem_response, exp.dresp, exp.iresp);
            check_word("fetch_stall", fetch_stall, exp.stall);
            check_word("fetch_enable", fetch_enable, exp.enable);
            // broadcast path, straight from memory
            check_word("mem_rdata", mem_rdata, mem_data);
            check_word("mem_rtag", mem_rtag, mem_tag);
            check_status(error_status, exp.status);
            model_owner = exp.next_owner;
            model_count = exp.next_count;
            model_halt  = exp.next_halt;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic condition_met(int which);
        case (which)
            until_imem:      condition_met = (imem_response != '0);
            until_data_bus:  condition_met = fetch_stall;
            until_dmem:      condition_met = (dmem_response != '0);
            until_fetch_bus: condition_met = !fetch_stall;
            until_halted:    condition_met = (error_status == mem_port_pkg::halted_on_wfi);
            default:         condition_met = (error_status == mem_port_pkg::illegal_inst);
        endcase
    endfunction

    task automatic wait_until(int which, string what, int limit);
        logic found;
        found = 1'b0;
        for (int n = 0; n < limit && !found; n++) begin
            @(negedge clock);
            found = condition_met(which);
        end
        if (!found) begin
            $display("timed out after %0d cycles waiting for %s", limit, what);
            stop_run();
        end
    endtask

    // one cycle of random traffic, halt left alone
    task automatic drive_random(logic with_data);
        int pick;
        @(posedge clock);
        pick = $urandom_range(3);
        imem_addr    <= $urandom;
        dcache_addr  <= $urandom;
        dcache_data  <= {$urandom, $urandom};
        dcache_size  <= mem_port_pkg::mem_size_t'($urandom_range(3));
        mem_response <= 4'($urandom_range(15));
        mem_data     <= {$urandom, $urandom};
        mem_tag      <= 4'($urandom_range(15));
        dispatch_ok  <= 1'($urandom_range(1));
        retire_stall <= ($urandom_range(3) == 0);
        halt_confirm <= 1'($urandom_range(1));
        illegal      <= ($urandom_range(7) == 0);
        if (!with_data || pick < 2) begin
            dcache_command <= mem_port_pkg::bus_none;
        end else if (pick == 2) begin
            dcache_command <= mem_port_pkg::bus_load;
        end else begin
            dcache_command <= mem_port_pkg::bus_store;
        end
    endtask

    initial begin
        int seed_draw;
        seed_draw      = $urandom(32'hcb6f_6c16);
        reset          = 1'b1;
        dcache_command = mem_port_pkg::bus_none;
        dcache_addr    = '0;
        dcache_data    = '0;
        dcache_size    = mem_port_pkg::size_byte;
        imem_addr      = '0;
        mem_response   = '0;
        mem_data       = '0;
        mem_tag        = '0;
        dispatch_ok    = 1'b1;
        retire_stall   = 1'b0;
        halt           = 1'b0;
        halt_confirm   = 1'b0;
        illegal        = 1'b0;
        repeat (8) @(posedge clock);
        reset        <= 1'b0;
        imem_addr    <= $urandom;
        mem_response <= 4'h5;
        // fetch owns the bus after the turnaround
        wait_until(until_imem, "an instruction response", 10);
        @(posedge clock);
        dcache_command <= mem_port_pkg::bus_store;
        dcache_addr    <= $urandom;
        dcache_data    <= {$urandom, $urandom};
        dcache_size    <= mem_port_pkg::size_word;
        mem_response   <= 4'h9;
        wait_until(until_data_bus, "the data side to own the bus", 10);
        wait_until(until_dmem, "a data response", 10);
        @(posedge clock);
        dcache_command <= mem_port_pkg::bus_none;
        wait_until(until_fetch_bus, "fetch to win the bus back", 10);
        repeat (300) drive_random(1'b1);
        // one cycle halt pulse, then confirm
        @(posedge clock);
        halt         <= 1'b1;
        illegal      <= 1'b0;
        halt_confirm <= 1'b0;
        @(posedge clock);
        halt         <= 1'b0;
        halt_confirm <= 1'b1;
        wait_until(until_halted, "the halted status", 10);
        repeat (100) drive_random(1'b1);
        // illegal over a confirmed halt
        @(posedge clock);
        illegal      <= 1'b1;
        halt_confirm <= 1'b1;
        wait_until(until_illegal, "the illegal instruction status", 5);
        @(negedge clock);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
mem_port_pkg.sv
request_select.sv
owner_tracker.sv
response_router.sv
halt_control.sv
mem_port_top.sv
mem_port_assert.sv
mem_port_tb.sv

/* Bender.yml */
package:
  name: mem_port

export_include_dirs:
  - .

sources:
  # design, package first
  - mem_port_pkg.sv
  - request_select.sv
  - owner_tracker.sv
  - response_router.sv
  - halt_control.sv
  - mem_port_top.sv
  # verification
  - target: test
    files:
      - mem_port_assert.sv
      - mem_port_tb.sv
